// ==== include/bridge_params.svh ====
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// AXI4-Lite host bus
`define AXI_ADDR_W      7
`define AXI_DATA_W      128

// Image size word fields
`define IMG_W_BITS      12
`define IMG_H_BITS      11
`define IMG_W_LSB       32
`define IMG_H_LSB       0

// DRAM read request
`define DRAM_ADDR_W     39
`define DRAM_LEN_W      8

// Write offsets
`define REG_IMAGE_FIFO  7'h00
`define REG_FLUSH       7'h10
`define REG_IMAGE_SIZE  7'h20
`define REG_DRAM_DATA   7'h30
`define REG_DRAM_DONE   7'h40

// Read offsets
`define REG_DRAM_REQ    7'h00

// Response codes
`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif

// ==== list.f ====
+incdir+include
rtl/img_bridge_pkg.sv
rtl/bridge_ctrl.sv
rtl/image_port.sv
rtl/dram_mailbox.sv
rtl/img_bridge_top.sv
verification/tb_img_bridge.sv

// ==== rtl/bridge_ctrl.sv ====
`include "bridge_params.svh"

module bridge_ctrl
    import img_bridge_pkg::*;
(
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,

    // Write address and data
    input  logic [`AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [`AXI_DATA_W-1:0]  s_axi_wdata,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,

    // Write response
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,

    // Read address and data
    input  logic [`AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [`AXI_DATA_W-1:0]  s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,

    // Back-pressure from the targets
    input  logic                    image_full,
    input  logic                    dram_buffer_full,

    input  dram_req_t               req,
    output wr_cmd_t                 cmd
);

    wr_state_e               wr_state;
    rd_state_e               rd_state;
    reg_op_e                 wr_op;
    logic                    wr_blocked;
    logic                    wr_accept;
    logic                    rd_accept;
    reg_op_e                 cmd_op;
    logic [`AXI_DATA_W-1:0]  cmd_data;
    logic [`AXI_DATA_W-1:0]  req_word;

    //////////////////////////////////////////////////////////////////////
    // Write decode and acceptance
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (s_axi_awaddr)
            `REG_IMAGE_FIFO: wr_op = OP_IMAGE_DATA;
            `REG_FLUSH:      wr_op = OP_FLUSH;
            `REG_IMAGE_SIZE: wr_op = OP_IMAGE_SIZE;
            `REG_DRAM_DATA:  wr_op = OP_DRAM_DATA;
            `REG_DRAM_DONE:  wr_op = OP_DRAM_DONE;
            default:         wr_op = OP_NONE;
        endcase
    end

    // Full targets hold the write in AW/W until they drain
    assign wr_blocked = (wr_op == OP_IMAGE_DATA && image_full) ||
                        (wr_op == OP_DRAM_DATA && dram_buffer_full);

    assign wr_accept = s_axi_awvalid && s_axi_wvalid &&
                       (wr_state == WR_IDLE) && !wr_blocked;

    assign s_axi_awready = wr_accept;
    assign s_axi_wready  = wr_accept;
    assign s_axi_bvalid  = (wr_state == WR_RESP);

    //////////////////////////////////////////////////////////////////////
    // Write response FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_state    <= WR_IDLE;
            s_axi_bresp <= `RESP_OKAY;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state    <= WR_RESP;
                        s_axi_bresp <= (wr_op == OP_NONE) ? `RESP_SLVERR : `RESP_OKAY;
                    end
                end
                WR_RESP: begin
                    if (s_axi_bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Command lives for exactly one cycle after the accept
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            cmd_op <= OP_NONE;
        end else begin
            cmd_op <= wr_accept ? wr_op : OP_NONE;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (wr_accept) begin
            cmd_data <= s_axi_wdata;
        end
    end

    assign cmd = '{op: cmd_op, data: cmd_data};

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////
    // Len in the upper half and addr in the lower half
    assign req_word = {{(`AXI_DATA_W/2 - `DRAM_LEN_W){1'b0}}, req.len,
                       {(`AXI_DATA_W/2 - `DRAM_ADDR_W){1'b0}}, req.addr};

    assign s_axi_arready = (rd_state == RD_IDLE);
    assign rd_accept     = s_axi_arvalid && s_axi_arready;
    assign s_axi_rvalid  = (rd_state == RD_DATA);

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_state    <= RD_IDLE;
            s_axi_rdata <= '0;
            s_axi_rresp <= `RESP_OKAY;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_accept) begin
                        rd_state <= RD_DATA;
                        if (s_axi_araddr == `REG_DRAM_REQ) begin
                            s_axi_rdata <= req_word;
                            s_axi_rresp <= `RESP_OKAY;
                        end else begin
                            s_axi_rdata <= '0;
                            s_axi_rresp <= `RESP_SLVERR;
                        end
                    end
                end
                RD_DATA: begin
                    if (s_axi_rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Protocol checks
    //////////////////////////////////////////////////////////////////////
    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else $error("bvalid dropped or bresp changed before bready");

    a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid dropped or rdata changed before rready");

    // Image writes only go out while the FIFO has room
    a_image_not_full: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        cmd.op == OP_IMAGE_DATA |-> $past(s_axi_awready && !image_full))
        else $error("image write accepted while image FIFO full");

endmodule

// ==== rtl/dram_mailbox.sv ====
`include "bridge_params.svh"

module dram_mailbox
    import img_bridge_pkg::*;
(
    input  logic                     s_axi_aclk,
    input  logic                     s_axi_aresetn,
    input  wr_cmd_t                  cmd,

    // DRAM read request from the far side
    input  logic                     dram_read_en,
    input  logic [`DRAM_ADDR_W-1:0]  dram_read_addr,
    input  logic [`DRAM_LEN_W-1:0]   dram_read_len,

    // Data buffer toward DRAM
    output logic [`AXI_DATA_W-1:0]   dram_data,
    output logic                     dram_data_valid,
    output logic                     dram_read_busy,

    output dram_req_t                req
);

    //////////////////////////////////////////////////////////////////////
    // Data buffer beats
    //////////////////////////////////////////////////////////////////////
    // Every beat is qualified including the last one
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            dram_data_valid <= 1'b0;
            dram_data       <= '0;
        end else begin
            dram_data_valid <= (cmd.op == OP_DRAM_DATA);
            if (cmd.op == OP_DRAM_DATA) begin
                dram_data <= cmd.data;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request latch and busy flag
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            req <= '0;
        end else if (dram_read_en) begin
            req.addr <= dram_read_addr;
            req.len  <= dram_read_len;
        end
    end

    // A new request beats a done write in the same cycle
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            dram_read_busy <= 1'b0;
        end else if (dram_read_en) begin
            dram_read_busy <= 1'b1;
        end else if (cmd.op == OP_DRAM_DONE) begin
            dram_read_busy <= 1'b0;
        end
    end

endmodule

// ==== rtl/image_port.sv ====
`include "bridge_params.svh"

module image_port
    import img_bridge_pkg::*;
(
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  wr_cmd_t                 cmd,

    // Image sender FIFO side
    output logic                    image_write,
    output logic [`AXI_DATA_W-1:0]  image_data,
    output logic                    image_flush,
    output logic [`IMG_W_BITS-1:0]  image_width,
    output logic [`IMG_H_BITS-1:0]  image_height
);

    //////////////////////////////////////////////////////////////////////
    // Write and flush pulses
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_write <= 1'b0;
            image_flush <= 1'b0;
            image_data  <= '0;
        end else begin
            image_write <= (cmd.op == OP_IMAGE_DATA);
            // Flush only when bit 0 of the word is set
            image_flush <= (cmd.op == OP_FLUSH) && cmd.data[0];
            if (cmd.op == OP_IMAGE_DATA) begin
                image_data <= cmd.data;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Image size registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_width  <= '0;
            image_height <= '0;
        end else if (cmd.op == OP_IMAGE_SIZE) begin
            image_width  <= cmd.data[`IMG_W_LSB +: `IMG_W_BITS];
            image_height <= cmd.data[`IMG_H_LSB +: `IMG_H_BITS];
        end
    end

    // One pulse at a time toward the FIFO
    a_write_flush_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(image_write && image_flush))
        else $error("image_write and image_flush high together");

endmodule

// ==== rtl/img_bridge_pkg.sv ====
`include "bridge_params.svh"

package img_bridge_pkg;

    //////////////////////////////////////////////////////////////////////
    // Decoded register operations
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_NONE,
        OP_IMAGE_DATA,
        OP_FLUSH,
        OP_IMAGE_SIZE,
        OP_DRAM_DATA,
        OP_DRAM_DONE
    } reg_op_e;

    // One-cycle command from the control block to the datapaths
    typedef struct packed {
        reg_op_e                 op;
        logic [`AXI_DATA_W-1:0]  data;
    } wr_cmd_t;

    // Latched DRAM read request
    typedef struct packed {
        logic [`DRAM_ADDR_W-1:0] addr;
        logic [`DRAM_LEN_W-1:0]  len;
    } dram_req_t;

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

endpackage

// ==== rtl/img_bridge_top.sv ====
`include "bridge_params.svh"

module img_bridge_top
    import img_bridge_pkg::*;
(
    input  logic                     s_axi_aclk,
    input  logic                     s_axi_aresetn,

    // AXI4-Lite write channels
    input  logic [`AXI_ADDR_W-1:0]   s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,
    input  logic [`AXI_DATA_W-1:0]   s_axi_wdata,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,
    output logic [1:0]               s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,

    // AXI4-Lite read channels
    input  logic [`AXI_ADDR_W-1:0]   s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    output logic [`AXI_DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]               s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,

    // Image sender
    input  logic                     image_full,
    output logic                     image_reset,
    output logic                     image_write,
    output logic [`AXI_DATA_W-1:0]   image_data,
    output logic                     image_flush,
    output logic [`IMG_W_BITS-1:0]   image_width,
    output logic [`IMG_H_BITS-1:0]   image_height,

    // DRAM side
    input  logic                     dram_buffer_full,
    input  logic                     dram_read_en,
    input  logic [`DRAM_ADDR_W-1:0]  dram_read_addr,
    input  logic [`DRAM_LEN_W-1:0]   dram_read_len,
    output logic [`AXI_DATA_W-1:0]   dram_data,
    output logic                     dram_data_valid,
    output logic                     dram_read_busy
);

    wr_cmd_t   cmd;
    dram_req_t req;

    assign image_reset = ~s_axi_aresetn;

    //////////////////////////////////////////////////////////////////////
    // Control and datapaths
    //////////////////////////////////////////////////////////////////////
    bridge_ctrl i_bridge_ctrl (
        .s_axi_aclk       (s_axi_aclk),
        .s_axi_aresetn    (s_axi_aresetn),
        .s_axi_awaddr     (s_axi_awaddr),
        .s_axi_awvalid    (s_axi_awvalid),
        .s_axi_awready    (s_axi_awready),
        .s_axi_wdata      (s_axi_wdata),
        .s_axi_wvalid     (s_axi_wvalid),
        .s_axi_wready     (s_axi_wready),
        .s_axi_bresp      (s_axi_bresp),
        .s_axi_bvalid     (s_axi_bvalid),
        .s_axi_bready     (s_axi_bready),
        .s_axi_araddr     (s_axi_araddr),
        .s_axi_arvalid    (s_axi_arvalid),
        .s_axi_arready    (s_axi_arready),
        .s_axi_rdata      (s_axi_rdata),
        .s_axi_rresp      (s_axi_rresp),
        .s_axi_rvalid     (s_axi_rvalid),
        .s_axi_rready     (s_axi_rready),
        .image_full       (image_full),
        .dram_buffer_full (dram_buffer_full),
        .req              (req),
        .cmd              (cmd)
    );

    image_port i_image_port (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cmd           (cmd),
        .image_write   (image_write),
        .image_data    (image_data),
        .image_flush   (image_flush),
        .image_width   (image_width),
        .image_height  (image_height)
    );

    dram_mailbox i_dram_mailbox (
        .s_axi_aclk      (s_axi_aclk),
        .s_axi_aresetn   (s_axi_aresetn),
        .cmd             (cmd),
        .dram_read_en    (dram_read_en),
        .dram_read_addr  (dram_read_addr),
        .dram_read_len   (dram_read_len),
        .dram_data       (dram_data),
        .dram_data_valid (dram_data_valid),
        .dram_read_busy  (dram_read_busy),
        .req             (req)
    );

endmodule

// ==== verification/tb_img_bridge.sv ====
`include "bridge_params.svh"

module tb_img_bridge
    import img_bridge_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TRANS      = 300;
    localparam int RESET_CYCLES = 8;
    localparam int HS_LIMIT     = 64;

    // Pulse or register update expected on one sample cycle
    typedef struct packed {
        logic [31:0]             due;
        reg_op_e                 op;
        logic [`AXI_DATA_W-1:0]  data;
    } effect_t;

    logic                     s_axi_aclk;
    logic                     s_axi_aresetn;
    logic [`AXI_ADDR_W-1:0]   s_axi_awaddr;
    logic                     s_axi_awvalid;
    logic                     s_axi_awready;
    logic [`AXI_DATA_W-1:0]   s_axi_wdata;
    logic                     s_axi_wvalid;
    logic                     s_axi_wready;
    logic [1:0]               s_axi_bresp;
    logic                     s_axi_bvalid;
    logic                     s_axi_bready;
    logic [`AXI_ADDR_W-1:0]   s_axi_araddr;
    logic                     s_axi_arvalid;
    logic                     s_axi_arready;
    logic [`AXI_DATA_W-1:0]   s_axi_rdata;
    logic [1:0]               s_axi_rresp;
    logic                     s_axi_rvalid;
    logic                     s_axi_rready;
    logic                     image_full;
    logic                     image_reset;
    logic                     image_write;
    logic [`AXI_DATA_W-1:0]   image_data;
    logic                     image_flush;
    logic [`IMG_W_BITS-1:0]   image_width;
    logic [`IMG_H_BITS-1:0]   image_height;
    logic                     dram_buffer_full;
    logic                     dram_read_en;
    logic [`DRAM_ADDR_W-1:0]  dram_read_addr;
    logic [`DRAM_LEN_W-1:0]   dram_read_len;
    logic [`AXI_DATA_W-1:0]   dram_data;
    logic                     dram_data_valid;
    logic                     dram_read_busy;

    integer                   seed     = 32'h372d14fa;
    integer                   env_seed = 32'h372d14fa ^ 32'h0badcafe;
    int                       check_count;
    int                       error_count;

    // Model state
    effect_t                  effects[$];
    effect_t                  fx;
    int                       cycle;
    int                       reset_seen;
    reg_op_e                  wr_op;
    reg_op_e                  due_op;
    logic                     wr_acc;
    logic                     rd_acc;
    logic                     exp_bvalid;
    logic [1:0]               exp_bresp;
    logic                     exp_rvalid;
    logic [1:0]               exp_rresp;
    logic [`AXI_DATA_W-1:0]   exp_rdata;
    logic                     exp_busy;
    logic                     done_d1;
    logic [`DRAM_ADDR_W-1:0]  exp_addr;
    logic [`DRAM_LEN_W-1:0]   exp_len;
    logic [`IMG_W_BITS-1:0]   exp_width;
    logic [`IMG_H_BITS-1:0]   exp_height;

    img_bridge_top i_img_bridge_top (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #4 s_axi_aclk = ~s_axi_aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [`AXI_DATA_W-1:0] expected,
                               input logic [`AXI_DATA_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task report_and_finish;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    function automatic logic [`AXI_DATA_W-1:0] random_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Offset map of the register bridge
    function automatic reg_op_e decode_write(input logic [`AXI_ADDR_W-1:0] addr);
        case (addr)
            `REG_IMAGE_FIFO: return OP_IMAGE_DATA;
            `REG_FLUSH:      return OP_FLUSH;
            `REG_IMAGE_SIZE: return OP_IMAGE_SIZE;
            `REG_DRAM_DATA:  return OP_DRAM_DATA;
            `REG_DRAM_DONE:  return OP_DRAM_DONE;
            default:         return OP_NONE;
        endcase
    endfunction

    task automatic write_register(input logic [`AXI_ADDR_W-1:0] addr,
                                  input logic [`AXI_DATA_W-1:0] data, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        @(negedge s_axi_aclk);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        while (!ok && waited < HS_LIMIT) begin
            @(posedge s_axi_aclk);
            ok = s_axi_awready && s_axi_wready;
            waited++;
        end
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        if (!ok) begin
            error_count++;
            $display("Write to offset %0h was never accepted", addr);
        end
    endtask

    task automatic read_register(input logic [`AXI_ADDR_W-1:0] addr, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        @(negedge s_axi_aclk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!ok && waited < HS_LIMIT) begin
            @(posedge s_axi_aclk);
            ok = s_axi_arready;
            waited++;
        end
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        if (!ok) begin
            error_count++;
            $display("Read of offset %0h was never accepted", addr);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Model and checks sampled on the rising edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            if (reset_seen > 0) begin
                check_value("s_axi_bvalid", 0, s_axi_bvalid);
                check_value("s_axi_rvalid", 0, s_axi_rvalid);
                check_value("image_write", 0, image_write);
                check_value("image_flush", 0, image_flush);
                check_value("dram_data_valid", 0, dram_data_valid);
                check_value("dram_read_busy", 0, dram_read_busy);
                check_value("image_reset", 1, image_reset);
            end
            reset_seen++;
            cycle      = 0;
            exp_bvalid = 1'b0;
            exp_rvalid = 1'b0;
            exp_busy   = 1'b0;
            done_d1    = 1'b0;
            exp_addr   = '0;
            exp_len    = '0;
            exp_width  = '0;
            exp_height = '0;
            effects.delete();
        end else begin
            cycle++;
            wr_op  = decode_write(s_axi_awaddr);
            wr_acc = s_axi_awvalid && s_axi_wvalid && !exp_bvalid &&
                     !(wr_op == OP_IMAGE_DATA && image_full) &&
                     !(wr_op == OP_DRAM_DATA && dram_buffer_full);
            rd_acc = s_axi_arvalid && !exp_rvalid;

            check_value("s_axi_awready", wr_acc, s_axi_awready);
            check_value("s_axi_wready", wr_acc, s_axi_wready);
            check_value("s_axi_bvalid", exp_bvalid, s_axi_bvalid);
            if (exp_bvalid)
                check_value("s_axi_bresp", exp_bresp, s_axi_bresp);
            check_value("s_axi_arready", !exp_rvalid, s_axi_arready);
            check_value("s_axi_rvalid", exp_rvalid, s_axi_rvalid);
            if (exp_rvalid) begin
                check_value("s_axi_rdata", exp_rdata, s_axi_rdata);
                check_value("s_axi_rresp", exp_rresp, s_axi_rresp);
            end

            // At most one effect per cycle since writes are accepted one at a time
            due_op = OP_NONE;
            if (effects.size() > 0 && effects[0].due == cycle) begin
                fx     = effects.pop_front();
                due_op = fx.op;
                if (fx.op == OP_IMAGE_SIZE) begin
                    exp_width  = fx.data[`IMG_W_LSB +: `IMG_W_BITS];
                    exp_height = fx.data[`IMG_H_LSB +: `IMG_H_BITS];
                end
            end
            check_value("image_write", due_op == OP_IMAGE_DATA, image_write);
            if (due_op == OP_IMAGE_DATA)
                check_value("image_data", fx.data, image_data);
            check_value("image_flush", due_op == OP_FLUSH, image_flush);
            check_value("dram_data_valid", due_op == OP_DRAM_DATA, dram_data_valid);
            if (due_op == OP_DRAM_DATA)
                check_value("dram_data", fx.data, dram_data);
            check_value("image_width", exp_width, image_width);
            check_value("image_height", exp_height, image_height);
            check_value("dram_read_busy", exp_busy, dram_read_busy);
            check_value("image_reset", 0, image_reset);

            // Next-cycle predictions
            if (exp_bvalid && s_axi_bready)
                exp_bvalid = 1'b0;
            if (wr_acc) begin
                exp_bvalid = 1'b1;
                exp_bresp  = (wr_op == OP_NONE) ? `RESP_SLVERR : `RESP_OKAY;
                fx.due  = cycle + 2;
                fx.op   = wr_op;
                fx.data = s_axi_wdata;
                if (!(wr_op == OP_NONE || wr_op == OP_DRAM_DONE ||
                      (wr_op == OP_FLUSH && !s_axi_wdata[0])))
                    effects.push_back(fx);
            end
            if (exp_rvalid && s_axi_rready)
                exp_rvalid = 1'b0;
            if (rd_acc) begin
                exp_rvalid = 1'b1;
                exp_rdata  = '0;
                exp_rresp  = `RESP_SLVERR;
                if (s_axi_araddr == `REG_DRAM_REQ) begin
                    exp_rdata[64 +: `DRAM_LEN_W] = exp_len;
                    exp_rdata[0 +: `DRAM_ADDR_W] = exp_addr;
                    exp_rresp = `RESP_OKAY;
                end
            end
            // A new request wins over a done write in the same cycle
            if (dram_read_en)
                exp_busy = 1'b1;
            else if (done_d1)
                exp_busy = 1'b0;
            done_d1 = wr_acc && wr_op == OP_DRAM_DONE;
            if (dram_read_en) begin
                exp_addr = dram_read_addr;
                exp_len  = dram_read_len;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    // Back-pressure, response stalls and DRAM requests
    initial begin
        logic [63:0] rnd;
        image_full       = 1'b0;
        dram_buffer_full = 1'b0;
        s_axi_bready     = 1'b0;
        s_axi_rready     = 1'b0;
        dram_read_en     = 1'b0;
        dram_read_addr   = '0;
        dram_read_len    = '0;
        @(posedge s_axi_aresetn);
        forever begin
            @(negedge s_axi_aclk);
            image_full       = ($random(env_seed) & 3) == 0;
            dram_buffer_full = ($random(env_seed) & 3) == 0;
            s_axi_bready     = ($random(env_seed) & 3) != 0;
            s_axi_rready     = ($random(env_seed) & 3) != 0;
            dram_read_en     = ($random(env_seed) & 7) == 0;
            rnd              = {$random(env_seed), $random(env_seed)};
            dram_read_addr   = rnd[`DRAM_ADDR_W-1:0];
            dram_read_len    = rnd[63 -: `DRAM_LEN_W];
        end
    end

    initial begin
        int                      sel;
        int                      waited;
        bit                      ok;
        logic [31:0]             rnd;
        logic [`AXI_ADDR_W-1:0]  addr;
        ok            = 1'b1;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;

        for (int i = 0; i < N_TRANS && ok; i++) begin
            sel = $random(seed) & 15;
            rnd = $random(seed);
            if (sel < 10) begin
                case (sel)
                    0, 1, 2: addr = `REG_IMAGE_FIFO;
                    3:       addr = `REG_FLUSH;
                    4:       addr = `REG_IMAGE_SIZE;
                    5, 6, 7: addr = `REG_DRAM_DATA;
                    8:       addr = `REG_DRAM_DONE;
                    default: addr = rnd[`AXI_ADDR_W-1:0];
                endcase
                write_register(addr, random_word(), ok);
            end else begin
                addr = rnd[8] ? `REG_DRAM_REQ : rnd[`AXI_ADDR_W-1:0];
                read_register(addr, ok);
            end
        end

        if (ok) begin
            waited = 0;
            while ((s_axi_bvalid || s_axi_rvalid) && waited < HS_LIMIT) begin
                @(negedge s_axi_aclk);
                waited++;
            end
            if (s_axi_bvalid || s_axi_rvalid) begin
                error_count++;
                $display("A write or read response was never taken by the host");
            end
            repeat (4) @(negedge s_axi_aclk);
            if (effects.size() != 0) begin
                error_count++;
                $display("%0d expected datapath pulses never appeared", effects.size());
            end
        end
        report_and_finish();
    end

    // Watchdog
    initial begin
        repeat (N_TRANS * 40 + RESET_CYCLES) @(posedge s_axi_aclk);
        error_count++;
        $display("Watchdog expired before the test sequence finished");
        report_and_finish();
    end

endmodule
